/* Makefile */
# Verilator build and run of the branch predictor testbench
VERILATOR ?= verilator
TOP       ?= bpred_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, fail unless $(LOG) shows a pass"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+include
rtl/bpred_pkg.sv
rtl/bpred_btb.sv
rtl/bpred_ras.sv
rtl/bpred_next_pc.sv
rtl/bpred_if_buf.sv
rtl/bpred_top.sv
testbench/bpred_sva.sv
testbench/bpred_tb.sv

/* include/bpred_cfg.svh */
`ifndef BPRED_CFG_SVH
`define BPRED_CFG_SVH

// Fetch and target address width
`define BPRED_XLEN 32

// Direct-mapped BTB size, power of two
// 16 entries index on PC bits [5:2]
`define BPRED_BTB_ENTRIES 16

// Return address stack depth, power of two
`define BPRED_RAS_DEPTH 4

`endif

/* rtl/bpred_btb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

module bpred_btb (
  input  logic              clk,
  input  logic              rst_n,

  // Lookup on the current fetch address
  input  bpred_pkg::addr_t  fetch_pc,

  // Resolve port from execute
  input  logic              upd_valid,
  input  bpred_pkg::addr_t  upd_pc,
  input  bpred_pkg::addr_t  upd_target,
  input  logic              upd_taken,
  input  logic              upd_is_return,

  // Raw entry fields, not yet qualified by hit
  output logic              hit,
  output logic              taken,
  output bpred_pkg::addr_t  target,
  output logic              is_return
);

  import bpred_pkg::*;

  // Index field sits right above the word offset
  localparam int unsigned IDX_LO = 2;
  localparam int unsigned TAG_LO = IDX_LO + BTB_IDX_W;

  // Entry storage
  logic     valid_q  [`BPRED_BTB_ENTRIES];
  btb_tag_t tag_q    [`BPRED_BTB_ENTRIES];
  addr_t    target_q [`BPRED_BTB_ENTRIES];
  logic     taken_q  [`BPRED_BTB_ENTRIES];
  logic     ret_q    [`BPRED_BTB_ENTRIES];

  btb_idx_t rd_idx;
  btb_tag_t rd_tag;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;

  // Split the fetch and update addresses into index and tag
  assign rd_idx = fetch_pc[TAG_LO-1:IDX_LO];
  assign rd_tag = fetch_pc[`BPRED_XLEN-1:TAG_LO];
  assign wr_idx = upd_pc[TAG_LO-1:IDX_LO];
  assign wr_tag = upd_pc[`BPRED_XLEN-1:TAG_LO];

  // Zero-latency lookup, SRAM style
  assign hit       = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign taken     = taken_q[rd_idx];
  assign target    = target_q[rd_idx];
  assign is_return = ret_q[rd_idx];

  // Valid bits are the only control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `BPRED_BTB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (upd_valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Payload arrays
  // A resolve always overwrites, no replacement choice in direct-mapped
  always_ff @(posedge clk) begin
    if (upd_valid) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= upd_target;
      taken_q[wr_idx]  <= upd_taken;
      ret_q[wr_idx]    <= upd_is_return;
    end
  end

endmodule

`default_nettype wire

/* rtl/bpred_if_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module bpred_if_buf (
  input  logic              clk,
  input  logic              rst_n,

  // Hazard control from the pipeline
  input  logic              if_id_stall,
  input  logic              if_id_flush,

  // Prediction made in IF
  input  logic              pred_hit,
  input  logic              pred_taken,
  input  logic              pred_is_return,
  input  logic              pred_ras_valid,
  input  bpred_pkg::addr_t  btb_target,
  input  bpred_pkg::addr_t  ras_target,

  // Same prediction as seen by ID
  output logic              btb_hit_id,
  output logic              btb_pred_taken_id,
  output bpred_pkg::addr_t  btb_target_id,
  output logic              btb_is_return_id,
  output logic              ras_valid_id,
  output bpred_pkg::addr_t  ras_target_id
);

  // Flags qualify the targets, so only they are cleared
  // Flush wins over stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btb_hit_id        <= 1'b0;
      btb_pred_taken_id <= 1'b0;
      btb_is_return_id  <= 1'b0;
      ras_valid_id      <= 1'b0;
    end else if (if_id_flush) begin
      btb_hit_id        <= 1'b0;
      btb_pred_taken_id <= 1'b0;
      btb_is_return_id  <= 1'b0;
      ras_valid_id      <= 1'b0;
    end else if (!if_id_stall) begin
      btb_hit_id        <= pred_hit;
      btb_pred_taken_id <= pred_taken;
      btb_is_return_id  <= pred_is_return;
      ras_valid_id      <= pred_ras_valid;
    end
  end

  // Target payload, held during stall
  always_ff @(posedge clk) begin
    if (!if_id_stall) begin
      btb_target_id <= btb_target;
      ras_target_id <= ras_target;
    end
  end

endmodule

`default_nettype wire

/* rtl/bpred_next_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module bpred_next_pc (
  input  bpred_pkg::addr_t  fetch_pc,

  // Raw BTB fields
  input  logic              btb_hit,
  input  logic              btb_taken,
  input  bpred_pkg::addr_t  btb_target,
  input  logic              btb_is_return,

  // RAS top
  input  logic              ras_valid,
  input  bpred_pkg::addr_t  ras_target,

  output bpred_pkg::addr_t  next_pc,

  // Hit-qualified prediction for the IF/ID buffer
  output logic              pred_hit,
  output logic              pred_taken,
  output logic              pred_is_return,
  output logic              pred_ras_valid
);

  import bpred_pkg::*;

  // Fall-through is the next word
  localparam addr_t PC_STEP = addr_t'(4);

  logic use_ras;
  logic use_btb;

  // A return entry only redirects to the RAS while the stack holds something
  assign use_ras = btb_hit && btb_is_return && ras_valid;
  // Taken hit covers a return on an empty stack too
  assign use_btb = btb_hit && btb_taken;

  // Priority RAS, then BTB, then sequential
  always_comb begin
    if (use_ras) begin
      next_pc = ras_target;
    end else if (use_btb) begin
      next_pc = btb_target;
    end else begin
      next_pc = fetch_pc + PC_STEP;
    end
  end

  // Raw entry fields mean nothing on a miss
  assign pred_hit       = btb_hit;
  assign pred_taken     = btb_hit && btb_taken;
  assign pred_is_return = btb_hit && btb_is_return;
  // Stack state is independent of the BTB lookup
  assign pred_ras_valid = ras_valid;

endmodule

`default_nettype wire

/* rtl/bpred_pkg.sv */
`default_nettype none

`include "bpred_cfg.svh"

package bpred_pkg;

  // Width of the BTB index, taken from PC bits above the byte offset
  localparam int unsigned BTB_IDX_W = $clog2(`BPRED_BTB_ENTRIES);

  // RAS pointer width
  localparam int unsigned RAS_PTR_W = $clog2(`BPRED_RAS_DEPTH);

  typedef logic [`BPRED_XLEN-1:0] addr_t;
  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  // Tag is everything above the index and the 2-bit word offset
  typedef logic [`BPRED_XLEN-BTB_IDX_W-3:0] btb_tag_t;
  typedef logic [RAS_PTR_W-1:0] ras_ptr_t;
  // One extra bit so a full stack can be counted
  typedef logic [RAS_PTR_W:0] ras_cnt_t;

endpackage

`default_nettype wire

/* rtl/bpred_ras.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

module bpred_ras (
  input  logic              clk,
  input  logic              rst_n,

  // Resolve port, only the call and return view
  input  logic              upd_valid,
  input  bpred_pkg::addr_t  upd_pc,
  input  logic              upd_is_call,
  input  logic              upd_is_return,

  // Top of stack
  output logic              top_valid,
  output bpred_pkg::addr_t  top_target
);

  import bpred_pkg::*;

  // Return address of a call is the next sequential instruction
  localparam addr_t PC_STEP = addr_t'(4);
  localparam ras_cnt_t FULL_CNT = ras_cnt_t'(`BPRED_RAS_DEPTH);

  // Circular stack, wr_ptr_q is the next free slot
  addr_t    stack_q [`BPRED_RAS_DEPTH];
  ras_ptr_t wr_ptr_q;
  ras_cnt_t count_q;

  ras_ptr_t top_ptr;
  logic     push;
  logic     pop;

  assign top_ptr = ras_ptr_t'(wr_ptr_q - 1'b1);

  assign push = upd_valid && upd_is_call;
  // Popping an empty stack is ignored
  assign pop  = upd_valid && upd_is_return && (count_q != '0);

  assign top_valid  = (count_q != '0);
  assign top_target = stack_q[top_ptr];

  // Pointer and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      case ({push, pop})
        2'b10: begin
          // Wraps over the oldest entry when full
          wr_ptr_q <= ras_ptr_t'(wr_ptr_q + 1'b1);
          if (count_q != FULL_CNT) begin
            count_q <= ras_cnt_t'(count_q + 1'b1);
          end
        end
        2'b01: begin
          wr_ptr_q <= top_ptr;
          count_q  <= ras_cnt_t'(count_q - 1'b1);
        end
        // Call and return together replace the top, depth unchanged
        default: ;
      endcase
    end
  end

  // Stack contents
  always_ff @(posedge clk) begin
    if (push && pop) begin
      stack_q[top_ptr] <= upd_pc + PC_STEP;
    end else if (push) begin
      stack_q[wr_ptr_q] <= upd_pc + PC_STEP;
    end
  end

endmodule

`default_nettype wire

/* rtl/bpred_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bpred_top (
  input  logic              clk,
  input  logic              rst_n,

  // Current fetch address
  input  bpred_pkg::addr_t  fetch_pc,

  // Resolve port from execute
  input  logic              upd_valid,
  input  bpred_pkg::addr_t  upd_pc,
  input  bpred_pkg::addr_t  upd_target,
  input  logic              upd_taken,
  input  logic              upd_is_call,
  input  logic              upd_is_return,

  // Hazard control
  input  logic              if_id_stall,
  input  logic              if_id_flush,

  // Predicted fetch address, same cycle
  output bpred_pkg::addr_t  next_pc,

  // Prediction registered for ID
  output logic              btb_hit_id,
  output logic              btb_pred_taken_id,
  output bpred_pkg::addr_t  btb_target_id,
  output logic              btb_is_return_id,
  output logic              ras_valid_id,
  output bpred_pkg::addr_t  ras_target_id
);

  import bpred_pkg::*;

  // Raw BTB lookup
  logic  btb_hit;
  logic  btb_taken;
  addr_t btb_target;
  logic  btb_is_return;

  // RAS top of stack
  logic  ras_valid;
  addr_t ras_target;

  // Gated prediction going into the IF/ID buffer
  logic  pred_hit;
  logic  pred_taken;
  logic  pred_is_return;
  logic  pred_ras_valid;

  bpred_btb btb_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_pc      (fetch_pc),
    .upd_valid     (upd_valid),
    .upd_pc        (upd_pc),
    .upd_target    (upd_target),
    .upd_taken     (upd_taken),
    .upd_is_return (upd_is_return),
    .hit           (btb_hit),
    .taken         (btb_taken),
    .target        (btb_target),
    .is_return     (btb_is_return)
  );

  bpred_ras ras_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .upd_valid     (upd_valid),
    .upd_pc        (upd_pc),
    .upd_is_call   (upd_is_call),
    .upd_is_return (upd_is_return),
    .top_valid     (ras_valid),
    .top_target    (ras_target)
  );

  bpred_next_pc next_pc_i (
    .fetch_pc       (fetch_pc),
    .btb_hit        (btb_hit),
    .btb_taken      (btb_taken),
    .btb_target     (btb_target),
    .btb_is_return  (btb_is_return),
    .ras_valid      (ras_valid),
    .ras_target     (ras_target),
    .next_pc        (next_pc),
    .pred_hit       (pred_hit),
    .pred_taken     (pred_taken),
    .pred_is_return (pred_is_return),
    .pred_ras_valid (pred_ras_valid)
  );

  bpred_if_buf if_buf_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .if_id_stall       (if_id_stall),
    .if_id_flush       (if_id_flush),
    .pred_hit          (pred_hit),
    .pred_taken        (pred_taken),
    .pred_is_return    (pred_is_return),
    .pred_ras_valid    (pred_ras_valid),
    .btb_target        (btb_target),
    .ras_target        (ras_target),
    .btb_hit_id        (btb_hit_id),
    .btb_pred_taken_id (btb_pred_taken_id),
    .btb_target_id     (btb_target_id),
    .btb_is_return_id  (btb_is_return_id),
    .ras_valid_id      (ras_valid_id),
    .ras_target_id     (ras_target_id)
  );

endmodule

`default_nettype wire

/* testbench/bpred_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module bpred_sva (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              if_id_stall,
  input  logic              if_id_flush,

  // Raw predictor state inside the top level
  input  logic              btb_hit,
  input  logic              btb_is_return,
  input  logic              ras_valid,
  input  bpred_pkg::addr_t  ras_target,
  input  bpred_pkg::addr_t  next_pc,

  // ID side of the buffer
  input  logic              btb_hit_id,
  input  logic              btb_pred_taken_id,
  input  bpred_pkg::addr_t  btb_target_id,
  input  logic              btb_is_return_id,
  input  logic              ras_valid_id,
  input  bpred_pkg::addr_t  ras_target_id
);

  localparam int ID_W = 4 + 2 * $bits(bpred_pkg::addr_t);

  logic [3:0]      id_flags;
  logic [ID_W-1:0] id_word;

  assign id_flags = {btb_hit_id, btb_pred_taken_id, btb_is_return_id, ras_valid_id};
  assign id_word  = {id_flags, btb_target_id, ras_target_id};

  // Reset and flush both leave an empty ID slot
  a_id_clear: assert property (@(posedge clk)
    (!rst_n || if_id_flush) |=> (id_flags == 4'b0000))
    else $error("ID flags not cleared after reset or flush");

  // Stall freezes every ID output, targets too
  a_id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (if_id_stall && !if_id_flush) |=> (id_word === $past(id_word)))
    else $error("ID outputs changed during stall");

  // Return hit with a live stack must steer fetch to the RAS
  a_ras_select: assert property (@(posedge clk) disable iff (!rst_n)
    (btb_hit && btb_is_return && ras_valid) |-> (next_pc == ras_target))
    else $error("next_pc ignores RAS target on return hit");

endmodule

`default_nettype wire

/* testbench/bpred_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bpred_tb;

  import bpred_pkg::*;

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 5;
  localparam string VEC_FILE     = "testbench/bpred_vectors.txt";

  // DUT inputs
  logic  clk;
  logic  rst_n;
  addr_t fetch_pc;
  logic  upd_valid;
  addr_t upd_pc;
  addr_t upd_target;
  logic  upd_taken;
  logic  upd_is_call;
  logic  upd_is_return;
  logic  if_id_stall;
  logic  if_id_flush;

  // DUT outputs
  addr_t next_pc;
  logic  btb_hit_id;
  logic  btb_pred_taken_id;
  addr_t btb_target_id;
  logic  btb_is_return_id;
  logic  ras_valid_id;
  addr_t ras_target_id;

  // Op code and the nine numeric columns of each line
  logic [7:0]       vec_op[$];
  logic [8:0][31:0] vec_col[$];

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;
  int cycle_limit = 1000;

  // What ID must show after the edge that follows the current line
  logic       id_pending;
  logic [3:0] id_flags_exp;
  addr_t      id_btb_exp;
  addr_t      id_ras_exp;

  bpred_top dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_pc          (fetch_pc),
    .upd_valid         (upd_valid),
    .upd_pc            (upd_pc),
    .upd_target        (upd_target),
    .upd_taken         (upd_taken),
    .upd_is_call       (upd_is_call),
    .upd_is_return     (upd_is_return),
    .if_id_stall       (if_id_stall),
    .if_id_flush       (if_id_flush),
    .next_pc           (next_pc),
    .btb_hit_id        (btb_hit_id),
    .btb_pred_taken_id (btb_pred_taken_id),
    .btb_target_id     (btb_target_id),
    .btb_is_return_id  (btb_is_return_id),
    .ras_valid_id      (ras_valid_id),
    .ras_target_id     (ras_target_id)
  );

  // Assertions see the internal predictor nets
  bind bpred_top bpred_sva sva_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .if_id_stall       (if_id_stall),
    .if_id_flush       (if_id_flush),
    .btb_hit           (btb_hit),
    .btb_is_return     (btb_is_return),
    .ras_valid         (ras_valid),
    .ras_target        (ras_target),
    .next_pc           (next_pc),
    .btb_hit_id        (btb_hit_id),
    .btb_pred_taken_id (btb_pred_taken_id),
    .btb_target_id     (btb_target_id),
    .btb_is_return_id  (btb_is_return_id),
    .ras_valid_id      (ras_valid_id),
    .ras_target_id     (ras_target_id)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Run limit, tightened once the vector count is known
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: vectors still running after %0d clock cycles", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_vectors(output bit ok);
    int               fd;
    int               n;
    int               ch;
    logic [7:0]       op;
    logic [8:0][31:0] col;
    ok = 1'b1;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      while (ok && !$feof(fd)) begin
        n = $fscanf(fd, " %c", op);
        if (n != 1) begin
          break;
        end
        if (op == "#") begin
          // Comment line, skip to its end
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                      col[3], col[4], col[5], col[6], col[7], col[8]);
          if (n != 9) begin
            $display("Vector line %0d has missing fields", vec_op.size() + 1);
            ok = 1'b0;
          end else begin
            vec_op.push_back(op);
            vec_col.push_back(col);
          end
        end
      end
      $fclose(fd);
    end
    if (vec_op.size() == 0) begin
      ok = 1'b0;
    end
  endtask

  // Drive one line; called on the falling edge
  task automatic apply_vector(input int k, output logic check_next, output addr_t next_exp);
    logic [7:0]       op;
    logic [8:0][31:0] col;
    logic [31:0]      rnd;
    op           = vec_op[k];
    col          = vec_col[k];
    upd_valid    = 1'b0;
    if_id_stall  = 1'b0;
    if_id_flush  = 1'b0;
    check_next   = 1'b1;
    next_exp     = col[5];
    id_pending   = 1'b1;
    id_flags_exp = col[6][3:0];
    id_btb_exp   = col[7];
    id_ras_exp   = col[8];
    case (op)
      "U": begin
        upd_valid     = 1'b1;
        upd_pc        = col[0];
        upd_target    = col[1];
        upd_taken     = col[2][0];
        upd_is_call   = col[3][0];
        upd_is_return = col[4][0];
        // Fetch keeps its old address, nothing to check
        check_next    = 1'b0;
        id_pending    = 1'b0;
      end
      "F": begin
        fetch_pc = col[0];
      end
      "M": begin
        // Random tag on an index that was never written, so always a miss
        rnd      = $urandom();
        fetch_pc = {rnd[31:6], col[0][5:2], 2'b00};
        next_exp = fetch_pc + 32'd4;
      end
      "S": begin
        if_id_stall = 1'b1;
        fetch_pc    = col[0];
      end
      "X": begin
        // Flush outranks a stall in the same cycle
        if_id_flush = 1'b1;
        if_id_stall = 1'b1;
        fetch_pc    = col[0];
      end
      default: begin
        error_count++;
        $display("Vector %0d has an unknown operation code", k);
        check_next = 1'b0;
        id_pending = 1'b0;
      end
    endcase
  endtask

  task automatic check_id_outputs();
    if (id_pending) begin
      check_value("btb_hit_id", 32'(btb_hit_id), 32'(id_flags_exp[3]));
      check_value("btb_pred_taken_id", 32'(btb_pred_taken_id), 32'(id_flags_exp[2]));
      check_value("btb_is_return_id", 32'(btb_is_return_id), 32'(id_flags_exp[1]));
      check_value("ras_valid_id", 32'(ras_valid_id), 32'(id_flags_exp[0]));
      // Targets only mean something when their flag is set
      if (id_flags_exp[3]) begin
        check_value("btb_target_id", btb_target_id, id_btb_exp);
      end
      if (id_flags_exp[0]) begin
        check_value("ras_target_id", ras_target_id, id_ras_exp);
      end
    end
  endtask

  initial begin
    bit    loaded;
    logic  check_next;
    addr_t next_exp;
    void'($urandom(68));
    rst_n         = 1'b0;
    fetch_pc      = '0;
    upd_valid     = 1'b0;
    upd_pc        = '0;
    upd_target    = '0;
    upd_taken     = 1'b0;
    upd_is_call   = 1'b0;
    upd_is_return = 1'b0;
    if_id_stall   = 1'b0;
    if_id_flush   = 1'b0;
    id_pending    = 1'b0;
    load_vectors(loaded);
    if (!loaded) begin
      $display("Vector file %s is missing, empty or malformed", VEC_FILE);
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      cycle_limit = 2 * vec_op.size() + 50;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int k = 0; k < vec_op.size(); k++) begin
        @(negedge clk);
        // ID now holds the result of the previous line
        check_id_outputs();
        apply_vector(k, check_next, next_exp);
        // next_pc is combinational, sample mid low phase
        #(CLK_PERIOD / 4);
        if (check_next) begin
          check_value("next_pc", next_pc, next_exp);
        end
      end
      @(negedge clk);
      check_id_outputs();
      $display("Vectors: %0d, checks: %0d, errors: %0d", vec_op.size(), check_count,
               error_count);
      if (error_count == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* testbench/bpred_vectors.txt */
# op pc target taken call ret exp_next exp_flags exp_btb_target exp_ras_target
# U update, F fetch, M miss fetch with random tag, S stall, X flush; flags = hit,tk,ret,ras
M 00000000 0 0 0 0 0 0 0 0
M 00000014 0 0 0 0 0 0 0 0
F 00001000 0 0 0 0 00001004 0 0 0
U 00001008 00002000 1 0 0 0 0 0 0
U 0000100c 00003000 0 0 0 0 0 0 0
F 00001008 0 0 0 0 00002000 c 00002000 0
S 00001010 0 0 0 0 00001014 c 00002000 0
S 00001010 0 0 0 0 00001014 c 00002000 0
X 00001010 0 0 0 0 00001014 0 0 0
F 0000100c 0 0 0 0 00001010 8 00003000 0
F 00002008 0 0 0 0 0000200c 0 0 0
U 00000c10 00000500 1 0 1 0 0 0 0
F 00000c10 0 0 0 0 00000500 e 00000500 0
U 00000100 00004000 1 1 0 0 0 0 0
U 00000404 00004000 1 1 0 0 0 0 0
U 00000804 00004000 1 1 0 0 0 0 0
M 00000038 0 0 0 0 0 1 0 00000808
F 00000c10 0 0 0 0 00000808 f 00000500 00000808
U 00000c10 00000500 1 0 1 0 0 0 0
F 00000c10 0 0 0 0 00000408 f 00000500 00000408
U 00000c10 00000500 1 0 1 0 0 0 0
F 00000c10 0 0 0 0 00000104 f 00000500 00000104
U 00000c10 00000500 1 0 1 0 0 0 0
F 00000c10 0 0 0 0 00000500 e 00000500 0
U 00000c10 00000500 1 0 1 0 0 0 0
F 00000c10 0 0 0 0 00000500 e 00000500 0
U 00000200 00004000 1 1 0 0 0 0 0
U 00000300 00004000 1 1 0 0 0 0 0
U 00000400 00004000 1 1 0 0 0 0 0
U 00000500 00004000 1 1 0 0 0 0 0
U 00000600 00004000 1 1 0 0 0 0 0
F 00000c10 0 0 0 0 00000604 f 00000500 00000604
U 00000c10 00000500 1 0 1 0 0 0 0
F 00000c10 0 0 0 0 00000504 f 00000500 00000504
U 00000c10 00000500 1 0 1 0 0 0 0
F 00000c10 0 0 0 0 00000404 f 00000500 00000404
U 00000c10 00000500 1 0 1 0 0 0 0
F 00000c10 0 0 0 0 00000304 f 00000500 00000304
U 00000c10 00000500 1 0 1 0 0 0 0
F 00000c10 0 0 0 0 00000500 e 00000500 0
M 00000018 0 0 0 0 0 0 0 0
